// File: source/csr_config.svh
// fixed for rv32 with m-mode only; CSR_N_PERF must stay below 32, one counter page
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// datapath
`define CSR_XLEN   32  // data word
`define CSR_ADDR_W 12  // csr address

// performance counters
`define CSR_N_PERF    11     // built-in event counters
`define CSR_PERF_PAGE 7'h3C  // addr[11:5] of the 0x780..0x79F window

// misa, MXL=1 (rv32) with C and I
`define CSR_MISA_VALUE ((32'd1 << 30) | (32'd1 << 8) | (32'd1 << 2))

// dcsr.xdebugver, external debug support per spec
`define CSR_DEBUG_VER 4'd4

`endif

// File: source/csr_addr_pkg.sv
// only the csrs listed here are decoded; user and supervisor csrs read zero
`default_nettype none

`include "csr_config.svh"

package csr_addr_pkg;

  // csr instruction operation
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,  // read only
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // named csr addresses
  typedef enum logic [`CSR_ADDR_W-1:0] {
    // machine
    CSR_MSTATUS   = 12'h300,
    CSR_MISA      = 12'h301,
    CSR_MTVEC     = 12'h305,
    CSR_MEPC      = 12'h341,
    CSR_MCAUSE    = 12'h342,
    CSR_MHARTID   = 12'hF14,
    // counter control, trigger slots reused
    CSR_TSELECT   = 12'h7A0,  // pcer
    CSR_TDATA1    = 12'h7A1,  // pcmr
    // debug
    CSR_DCSR      = 12'h7B0,
    CSR_DPC       = 12'h7B1,
    CSR_DSCRATCH0 = 12'h7B2,
    CSR_DSCRATCH1 = 12'h7B3
  } csr_num_e;

  // counter window view
  typedef struct packed {
    logic [6:0] page;  // CSR_PERF_PAGE hits the window
    logic [4:0] idx;   // counter number
  } csr_perf_addr_t;

  // one address, two decodes
  typedef union packed {
    csr_num_e       num;   // machine bank, pcer and pcmr
    csr_perf_addr_t perf;  // counter array
  } csr_addr_u;

endpackage

`default_nettype wire

// File: source/csr_state_pkg.sv
// m-mode only core, so mpp and dcsr.prv are tied to M in the banks
`default_nettype none

package csr_state_pkg;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_H = 2'b10,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // bit 5 marks an interrupt, 4:0 the code
  typedef enum logic [5:0] {
    EXC_CAUSE_INSN_ADDR_MISA = 6'h00,
    EXC_CAUSE_ILLEGAL_INSN   = 6'h02,
    EXC_CAUSE_BREAKPOINT     = 6'h03,
    EXC_CAUSE_LOAD_ACC_FAULT = 6'h05,
    EXC_CAUSE_ECALL_MMODE    = 6'h0B,
    EXC_CAUSE_IRQ_EXT_M      = 6'h2B
  } exc_cause_e;

  typedef enum logic [2:0] {
    DBG_CAUSE_NONE    = 3'h0,
    DBG_CAUSE_EBREAK  = 3'h1,
    DBG_CAUSE_TRIGGER = 3'h2,
    DBG_CAUSE_HALTREQ = 3'h3,
    DBG_CAUSE_STEP    = 3'h4
  } dbg_cause_e;

  // implemented part of mstatus
  typedef struct packed {
    logic      mie;
    logic      mpie;
    priv_lvl_e mpp;
  } mstatus_t;

  // dcsr, bit layout as in the debug spec
  typedef struct packed {
    logic [3:0]  xdebugver;  // 31:28
    logic [11:0] zero2;
    logic        ebreakm;    // 15
    logic        zero1;
    logic        ebreaks;
    logic        ebreaku;
    logic        stepie;
    logic        stopcount;
    logic        stoptime;
    dbg_cause_e  cause;      // 8:6
    logic        zero0;
    logic        mprven;
    logic        nmip;
    logic        step;       // 2
    priv_lvl_e   prv;        // 1:0
  } dcsr_t;

endpackage

`default_nettype wire

// File: source/csr_bus_if.sv
// one bank's side of a csr access; hit comes only from the bank's own decode
`timescale 1ns/100ps
`default_nettype none

`include "csr_config.svh"

interface csr_bus_if
  import csr_addr_pkg::*;
();

  csr_addr_u            addr;   // access address
  logic                 we;     // access with op other than none
  logic [`CSR_XLEN-1:0] wdata;  // word after the op
  logic [`CSR_XLEN-1:0] rdata;  // bank read word, zero if not owned
  logic                 hit;    // bank owns addr

  // access controller side
  modport ctrl (output addr, we, wdata, input rdata, hit);
  // register bank side
  modport bank (input addr, we, wdata, output rdata, hit);

endinterface

`default_nettype wire

// File: source/csr_machine_bank.sv
// save, mret and dret win over a csr write in the same cycle; mtvec is the boot address
`timescale 1ns/100ps
`default_nettype none

`include "csr_config.svh"

module csr_machine_bank
  import csr_addr_pkg::*;
  import csr_state_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  csr_bus_if.bank              bus_i,
  input  logic [`CSR_XLEN-1:0] boot_addr_i,
  input  logic [3:0]           core_id_i,
  input  logic [5:0]           cluster_id_i,
  input  logic [`CSR_XLEN-1:0] pc_if_i,
  input  logic [`CSR_XLEN-1:0] pc_id_i,
  input  logic                 csr_save_if_i,
  input  logic                 csr_save_id_i,
  input  logic                 csr_save_cause_i,
  input  logic                 csr_restore_mret_i,
  input  logic                 csr_restore_dret_i,
  input  logic                 debug_csr_save_i,
  input  exc_cause_e           csr_cause_i,
  input  dbg_cause_e           debug_cause_i,
  output logic                 m_irq_enable_o,
  output logic [`CSR_XLEN-1:0] mepc_o,
  output logic [`CSR_XLEN-1:0] depc_o,
  output logic                 debug_single_step_o,
  output logic                 debug_ebreakm_o
);

  mstatus_t             mstatus_q, mstatus_d;
  exc_cause_e           mcause_q, mcause_d;
  dcsr_t                dcsr_q, dcsr_d;
  logic [`CSR_XLEN-1:0] mepc_q, mepc_d;
  logic [`CSR_XLEN-1:0] depc_q, depc_d;
  logic [`CSR_XLEN-1:0] dscratch0_q, dscratch0_d;
  logic [`CSR_XLEN-1:0] dscratch1_q, dscratch1_d;
  logic [`CSR_XLEN-1:0] exc_pc;  // pc saved on a trap
  logic                 wr;      // csr write to an owned address

  ////////////////////
  // read decode
  ////////////////////

  always_comb begin
    bus_i.rdata = '0;
    bus_i.hit   = 1'b1;
    case (bus_i.addr.num)
      CSR_MSTATUS: bus_i.rdata = {19'b0, mstatus_q.mpp, 3'b0, mstatus_q.mpie,
                                  3'b0, mstatus_q.mie, 3'b0};
      CSR_MISA:      bus_i.rdata = `CSR_MISA_VALUE;
      CSR_MTVEC:     bus_i.rdata = boot_addr_i;  // vectors sit at boot
      CSR_MEPC:      bus_i.rdata = mepc_q;
      CSR_MCAUSE:    bus_i.rdata = {mcause_q[5], 26'b0, mcause_q[4:0]};
      CSR_MHARTID:   bus_i.rdata = {21'b0, cluster_id_i, 1'b0, core_id_i};
      CSR_DCSR:      bus_i.rdata = dcsr_q;
      CSR_DPC:       bus_i.rdata = depc_q;
      CSR_DSCRATCH0: bus_i.rdata = dscratch0_q;
      CSR_DSCRATCH1: bus_i.rdata = dscratch1_q;
      default:       bus_i.hit   = 1'b0;  // not ours, reads zero
    endcase
  end

  assign wr = bus_i.we & bus_i.hit;

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    mstatus_d   = mstatus_q;
    mcause_d    = mcause_q;
    dcsr_d      = dcsr_q;
    mepc_d      = mepc_q;
    depc_d      = depc_q;
    dscratch0_d = dscratch0_q;
    dscratch1_d = dscratch1_q;

    // csr instruction writes first
    if (wr) begin
      case (bus_i.addr.num)
        CSR_MSTATUS: begin
          mstatus_d.mie  = bus_i.wdata[3];
          mstatus_d.mpie = bus_i.wdata[7];
        end
        CSR_MEPC:   mepc_d   = bus_i.wdata;
        CSR_MCAUSE: mcause_d = exc_cause_e'({bus_i.wdata[31], bus_i.wdata[4:0]});
        CSR_DCSR: begin
          dcsr_d           = dcsr_t'(bus_i.wdata);
          dcsr_d.xdebugver = `CSR_DEBUG_VER;
          dcsr_d.prv       = PRIV_LVL_M;  // m-mode only
          dcsr_d.nmip      = 1'b0;        // unsupported features
          dcsr_d.mprven    = 1'b0;
          dcsr_d.stopcount = 1'b0;
          dcsr_d.stoptime  = 1'b0;
          dcsr_d.zero0     = 1'b0;
          dcsr_d.zero1     = 1'b0;
          dcsr_d.zero2     = '0;
        end
        CSR_DPC: begin
          if (!bus_i.wdata[0]) depc_d = bus_i.wdata;  // odd pc dropped
        end
        CSR_DSCRATCH0: dscratch0_d = bus_i.wdata;
        CSR_DSCRATCH1: dscratch1_d = bus_i.wdata;
        default: ;
      endcase
    end

    // which stage the trapping pc comes from
    case (1'b1)
      csr_save_if_i: exc_pc = pc_if_i;
      csr_save_id_i: exc_pc = pc_id_i;
      default:       exc_pc = pc_id_i;
    endcase

    // trap controller overrides, save then mret then dret
    if (csr_save_cause_i) begin
      if (debug_csr_save_i) begin
        // debug entry leaves machine trap state alone
        dcsr_d.prv   = PRIV_LVL_M;
        dcsr_d.cause = debug_cause_i;
        depc_d       = exc_pc;
      end else begin
        mstatus_d.mpie = mstatus_q.mie;
        mstatus_d.mie  = 1'b0;  // handler runs masked
        mepc_d         = exc_pc;
        mcause_d       = csr_cause_i;
      end
    end else if (csr_restore_mret_i) begin
      mstatus_d.mie  = mstatus_q.mpie;
      mstatus_d.mpie = 1'b1;
    end else if (csr_restore_dret_i) begin
      mstatus_d.mie  = mstatus_q.mpie;  // same as mret
      mstatus_d.mpie = 1'b1;
    end
  end

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mstatus_q <= '{mie: 1'b0, mpie: 1'b0, mpp: PRIV_LVL_M};
      mcause_q  <= exc_cause_e'('0);
      mepc_q    <= '0;
      depc_q    <= '0;
      dcsr_q    <= '{xdebugver: `CSR_DEBUG_VER, prv: PRIV_LVL_M,
                     cause: DBG_CAUSE_NONE, default: '0};
    end else begin
      mstatus_q <= '{mie: mstatus_d.mie, mpie: mstatus_d.mpie, mpp: PRIV_LVL_M};
      mcause_q  <= mcause_d;
      mepc_q    <= mepc_d;
      depc_q    <= depc_d;
      dcsr_q    <= dcsr_d;
    end
  end

  // scratch words, no reset
  always_ff @(posedge clk_i) begin
    dscratch0_q <= dscratch0_d;
    dscratch1_q <= dscratch1_d;
  end

  assign m_irq_enable_o      = mstatus_q.mie;
  assign mepc_o              = mepc_q;
  assign depc_o              = depc_q;
  assign debug_single_step_o = dcsr_q.step;
  assign debug_ebreakm_o     = dcsr_q.ebreakm;

endmodule

`default_nettype wire

// File: source/csr_perf_bank.sv
// events count one cycle late; indexes at or above CSR_N_PERF in the page are not owned
`timescale 1ns/100ps
`default_nettype none

`include "csr_config.svh"

module csr_perf_bank
  import csr_addr_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  csr_bus_if.bank bus_i,
  input  logic    access_i,
  input  logic    if_valid_i,       // new instruction from IF
  input  logic    id_valid_i,       // ID stage done
  input  logic    is_compressed_i,
  input  logic    is_decoding_i,
  input  logic    imiss_i,          // fetch stall
  input  logic    pc_set_i,
  input  logic    jump_i,
  input  logic    branch_i,
  input  logic    branch_taken_i,
  input  logic    mem_load_i,
  input  logic    mem_store_i
);

  logic [`CSR_N_PERF-1:0]                pccr_in;     // raw events
  logic [`CSR_N_PERF-1:0]                pccr_inc_q;  // gated events, one cycle late
  logic [`CSR_N_PERF-1:0]                pcer_q;      // per-counter enable
  logic [1:0]                            pcmr_q;      // bit 0 enable, bit 1 saturate
  logic [`CSR_N_PERF-1:0][`CSR_XLEN-1:0] pccr_q, pccr_d;
  logic                                  is_pcer, is_pcmr, is_pccr;

  ////////////////////
  // event map
  ////////////////////

  assign pccr_in[0]  = 1'b1;                   // cycles
  assign pccr_in[1]  = if_valid_i;             // instructions
  assign pccr_in[2]  = 1'b0;                   // reserved
  assign pccr_in[3]  = 1'b0;                   // reserved
  assign pccr_in[4]  = imiss_i & ~pc_set_i;    // fetch stalls, not redirects
  assign pccr_in[5]  = mem_load_i;
  assign pccr_in[6]  = mem_store_i;
  assign pccr_in[7]  = jump_i;
  assign pccr_in[8]  = branch_i;
  assign pccr_in[9]  = branch_taken_i;
  assign pccr_in[10] = id_valid_i & is_decoding_i & is_compressed_i;

  ////////////////////
  // decode and read
  ////////////////////

  assign is_pcer = (bus_i.addr.num == CSR_TSELECT);
  assign is_pcmr = (bus_i.addr.num == CSR_TDATA1);
  assign is_pccr = (bus_i.addr.perf.page == `CSR_PERF_PAGE) &&
                   (bus_i.addr.perf.idx < 5'(`CSR_N_PERF));

  assign bus_i.hit = access_i & (is_pcer | is_pcmr | is_pccr);

  always_comb begin
    bus_i.rdata = '0;
    if (is_pcer) begin
      bus_i.rdata[`CSR_N_PERF-1:0] = pcer_q;
    end else if (is_pcmr) begin
      bus_i.rdata[1:0] = pcmr_q;
    end else if (is_pccr) begin
      bus_i.rdata = pccr_q[bus_i.addr.perf.idx];  // idx in range here
    end
  end

  ////////////////////
  // counter update
  ////////////////////

  always_comb begin
    for (int c = 0; c < `CSR_N_PERF; c++) begin
      pccr_d[c] = pccr_q[c];
      // saturate holds at all ones, else wrap
      if (pccr_inc_q[c] && (!pcmr_q[1] || (pccr_q[c] != '1))) begin
        pccr_d[c] = pccr_q[c] + 1'b1;
      end
      if (bus_i.we && is_pccr && (bus_i.addr.perf.idx == 5'(c))) begin
        pccr_d[c] = bus_i.wdata;  // write beats increment
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pcer_q     <= '0;     // nothing counts
      pcmr_q     <= 2'b11;  // enabled, saturating
      pccr_inc_q <= '0;
      pccr_q     <= '0;
    end else begin
      if (bus_i.we && is_pcer) pcer_q <= bus_i.wdata[`CSR_N_PERF-1:0];
      if (bus_i.we && is_pcmr) pcmr_q <= bus_i.wdata[1:0];
      pccr_inc_q <= pccr_in & pcer_q & {`CSR_N_PERF{pcmr_q[0]}};
      pccr_q     <= pccr_d;
    end
  end

endmodule

`default_nettype wire

// File: source/csr_access_ctrl.sv
// access always accepted in its cycle; perf bank read data wins when both banks hit
`timescale 1ns/100ps
`default_nettype none

`include "csr_config.svh"

module csr_access_ctrl
  import csr_addr_pkg::*;
(
  input  logic                   access_i,
  input  csr_op_e                op_i,
  input  logic [`CSR_ADDR_W-1:0] addr_i,
  input  logic [`CSR_XLEN-1:0]   wdata_i,
  output logic [`CSR_XLEN-1:0]   rdata_o,
  csr_bus_if.ctrl                mach_o,
  csr_bus_if.ctrl                perf_o
);

  csr_addr_u            addr;   // both views, banks pick theirs
  logic [`CSR_XLEN-1:0] wdata;  // old value combined with operand
  logic                 we;

  assign addr = csr_addr_u'(addr_i);

  // old value, zero when nobody owns the address
  assign rdata_o = perf_o.hit ? perf_o.rdata : mach_o.rdata;

  // one write rule for every register
  always_comb begin
    case (op_i)
      CSR_OP_SET:   wdata = rdata_o | wdata_i;
      CSR_OP_CLEAR: wdata = rdata_o & ~wdata_i;
      default:      wdata = wdata_i;  // write; none never stores
    endcase
  end

  assign we = access_i && (op_i != CSR_OP_NONE);

  // same word and strobe to both banks, each decodes its own
  assign mach_o.addr  = addr;
  assign mach_o.we    = we;
  assign mach_o.wdata = wdata;
  assign perf_o.addr  = addr;
  assign perf_o.we    = we;
  assign perf_o.wdata = wdata;

endmodule

`default_nettype wire

// File: source/csr_unit.sv
// single csr access per cycle with no back-pressure; csr_rdata_o is combinational
`timescale 1ns/100ps
`default_nettype none

`include "csr_config.svh"

module csr_unit
  import csr_addr_pkg::*;
  import csr_state_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // ids and boot
  input  logic [3:0]             core_id_i,
  input  logic [5:0]             cluster_id_i,
  input  logic [`CSR_XLEN-1:0]   boot_addr_i,
  // csr access
  input  logic                   csr_access_i,
  input  csr_op_e                csr_op_i,
  input  logic [`CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [`CSR_XLEN-1:0]   csr_wdata_i,
  output logic [`CSR_XLEN-1:0]   csr_rdata_o,
  // trap control
  input  logic [`CSR_XLEN-1:0]   pc_if_i,
  input  logic [`CSR_XLEN-1:0]   pc_id_i,
  input  logic                   csr_save_if_i,
  input  logic                   csr_save_id_i,
  input  logic                   csr_save_cause_i,
  input  logic                   csr_restore_mret_i,
  input  logic                   csr_restore_dret_i,
  input  exc_cause_e             csr_cause_i,
  output logic                   m_irq_enable_o,
  output logic [`CSR_XLEN-1:0]   mepc_o,
  // debug
  input  logic                   debug_csr_save_i,
  input  dbg_cause_e             debug_cause_i,
  output logic [`CSR_XLEN-1:0]   depc_o,
  output logic                   debug_single_step_o,
  output logic                   debug_ebreakm_o,
  // counter events
  input  logic                   if_valid_i,
  input  logic                   id_valid_i,
  input  logic                   is_compressed_i,
  input  logic                   is_decoding_i,
  input  logic                   imiss_i,
  input  logic                   pc_set_i,
  input  logic                   jump_i,
  input  logic                   branch_i,
  input  logic                   branch_taken_i,
  input  logic                   mem_load_i,
  input  logic                   mem_store_i
);

  csr_bus_if mach_bus ();  // machine and debug registers
  csr_bus_if perf_bus ();  // counters, pcer, pcmr

  csr_access_ctrl u_access_ctrl (
    .access_i (csr_access_i),
    .op_i     (csr_op_i),
    .addr_i   (csr_addr_i),
    .wdata_i  (csr_wdata_i),
    .rdata_o  (csr_rdata_o),
    .mach_o   (mach_bus.ctrl),
    .perf_o   (perf_bus.ctrl)
  );

  csr_machine_bank u_machine_bank (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .bus_i               (mach_bus.bank),
    .boot_addr_i         (boot_addr_i),
    .core_id_i           (core_id_i),
    .cluster_id_i        (cluster_id_i),
    .pc_if_i             (pc_if_i),
    .pc_id_i             (pc_id_i),
    .csr_save_if_i       (csr_save_if_i),
    .csr_save_id_i       (csr_save_id_i),
    .csr_save_cause_i    (csr_save_cause_i),
    .csr_restore_mret_i  (csr_restore_mret_i),
    .csr_restore_dret_i  (csr_restore_dret_i),
    .debug_csr_save_i    (debug_csr_save_i),
    .csr_cause_i         (csr_cause_i),
    .debug_cause_i       (debug_cause_i),
    .m_irq_enable_o      (m_irq_enable_o),
    .mepc_o              (mepc_o),
    .depc_o              (depc_o),
    .debug_single_step_o (debug_single_step_o),
    .debug_ebreakm_o     (debug_ebreakm_o)
  );

  csr_perf_bank u_perf_bank (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .bus_i           (perf_bus.bank),
    .access_i        (csr_access_i),  // gates perf hit
    .if_valid_i      (if_valid_i),
    .id_valid_i      (id_valid_i),
    .is_compressed_i (is_compressed_i),
    .is_decoding_i   (is_decoding_i),
    .imiss_i         (imiss_i),
    .pc_set_i        (pc_set_i),
    .jump_i          (jump_i),
    .branch_i        (branch_i),
    .branch_taken_i  (branch_taken_i),
    .mem_load_i      (mem_load_i),
    .mem_store_i     (mem_store_i)
  );

endmodule

`default_nettype wire

// File: tests/tb_csr_unit.sv
// run from the project root; reads tests/csr_stimulus.txt, four hex words per command, kind F ends
`timescale 1ns/100ps
`default_nettype none

`include "csr_config.svh"

module tb_csr_unit
  import csr_addr_pkg::*;
  import csr_state_pkg::*;
();

  localparam int MAX_CMDS     = 256;
  localparam int CYC_PER_CMD  = 40;  // watchdog budget per stimulus line
  localparam int RESET_CYCLES = 8;

  // command kinds, first word of each stimulus line
  localparam logic [3:0] K_END_TEST = 4'h0;
  localparam logic [3:0] K_WRITE    = 4'h1;
  localparam logic [3:0] K_SET      = 4'h2;
  localparam logic [3:0] K_CLEAR    = 4'h3;
  localparam logic [3:0] K_READ     = 4'h4;
  localparam logic [3:0] K_TRAP     = 4'h5;
  localparam logic [3:0] K_MRET     = 4'h6;
  localparam logic [3:0] K_DEBUG    = 4'h7;
  localparam logic [3:0] K_BURST    = 4'h8;

  logic                   clk_i;
  logic                   rst_ni;
  logic [3:0]             core_id_i;
  logic [5:0]             cluster_id_i;
  logic [`CSR_XLEN-1:0]   boot_addr_i;
  logic                   csr_access_i;
  csr_op_e                csr_op_i;
  logic [`CSR_ADDR_W-1:0] csr_addr_i;
  logic [`CSR_XLEN-1:0]   csr_wdata_i;
  logic [`CSR_XLEN-1:0]   csr_rdata_o;
  logic [`CSR_XLEN-1:0]   pc_if_i;
  logic [`CSR_XLEN-1:0]   pc_id_i;
  logic                   csr_save_if_i;
  logic                   csr_save_id_i;
  logic                   csr_save_cause_i;
  logic                   csr_restore_mret_i;
  logic                   csr_restore_dret_i;
  exc_cause_e             csr_cause_i;
  logic                   m_irq_enable_o;
  logic [`CSR_XLEN-1:0]   mepc_o;
  logic                   debug_csr_save_i;
  dbg_cause_e             debug_cause_i;
  logic [`CSR_XLEN-1:0]   depc_o;
  logic                   debug_single_step_o;
  logic                   debug_ebreakm_o;
  logic                   if_valid_i;
  logic                   id_valid_i;
  logic                   is_compressed_i;
  logic                   is_decoding_i;
  logic                   imiss_i;
  logic                   pc_set_i;
  logic                   jump_i;
  logic                   branch_i;
  logic                   branch_taken_i;
  logic                   mem_load_i;
  logic                   mem_store_i;

  logic [31:0] stim_mem [0:4*MAX_CMDS-1];  // kind, addr or pc, operand, expected
  logic [31:0] exp_mepc;      // mepc model, only traps move it
  int          n_cmds;
  int          cycle_limit;
  int          cycle_cnt;
  int          err_cnt;
  int          test_err_cnt;  // errors since last end-of-test marker
  int          test_cnt;
  int          check_cnt;

  csr_unit u_csr_unit (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;  // 20 ns period
  end

  ////////////////////
  // helpers
  ////////////////////

  // strobes back to quiet, right after a rising edge
  task automatic drive_idle();
    csr_access_i       <= 1'b0;
    csr_op_i           <= CSR_OP_NONE;
    csr_save_if_i      <= 1'b0;
    csr_save_id_i      <= 1'b0;
    csr_save_cause_i   <= 1'b0;
    csr_restore_mret_i <= 1'b0;
    csr_restore_dret_i <= 1'b0;
    debug_csr_save_i   <= 1'b0;
    mem_load_i         <= 1'b0;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("FAILED %s expected %h got %h", name, exp, got);
    err_cnt++;
    test_err_cnt++;
  endtask

  // one access cycle; a write lands on the next edge
  task automatic issue_access(input csr_op_e op, input logic [11:0] addr,
                              input logic [31:0] data);
    @(posedge clk_i);
    drive_idle();
    csr_access_i <= 1'b1;
    csr_op_i     <= op;
    csr_addr_i   <= addr;
    csr_wdata_i  <= data;
  endtask

  task automatic read_expect(input logic [11:0] addr, input logic [31:0] exp);
    issue_access(CSR_OP_NONE, addr, 32'h0);
    @(negedge clk_i);  // rdata is combinational, settled mid-cycle
    check_cnt++;
    if (csr_rdata_o !== exp) begin
      report_mismatch($sformatf("csr_rdata_o @%h", addr), exp, csr_rdata_o);
    end
    // dcsr step and ebreakm also show on the debug outputs
    if (addr == CSR_DCSR) begin
      check_cnt += 2;
      if (debug_single_step_o !== exp[2]) begin
        report_mismatch("debug_single_step_o", {31'b0, exp[2]}, {31'b0, debug_single_step_o});
      end
      if (debug_ebreakm_o !== exp[15]) begin
        report_mismatch("debug_ebreakm_o", {31'b0, exp[15]}, {31'b0, debug_ebreakm_o});
      end
    end
  endtask

  task automatic trap_entry(input logic [31:0] pc, input logic [5:0] cause,
                            input logic [31:0] exp_epc);
    @(posedge clk_i);
    drive_idle();
    csr_save_cause_i <= 1'b1;
    csr_save_if_i    <= 1'b1;
    pc_if_i          <= pc;
    pc_id_i          <= ~pc;  // wrong stage, must not be saved
    csr_cause_i      <= exc_cause_e'(cause);
    @(posedge clk_i);
    drive_idle();
    @(negedge clk_i);
    check_cnt += 2;
    if (mepc_o !== exp_epc) report_mismatch("mepc_o", exp_epc, mepc_o);
    if (m_irq_enable_o !== 1'b0) report_mismatch("m_irq_enable_o", 32'h0, {31'b0, m_irq_enable_o});
    exp_mepc = exp_epc;
  endtask

  task automatic mret_exit(input logic exp_mie);
    @(posedge clk_i);
    drive_idle();
    csr_restore_mret_i <= 1'b1;
    @(posedge clk_i);
    drive_idle();
    @(negedge clk_i);
    check_cnt++;
    if (m_irq_enable_o !== exp_mie) begin
      report_mismatch("m_irq_enable_o", {31'b0, exp_mie}, {31'b0, m_irq_enable_o});
    end
  endtask

  task automatic debug_entry(input logic [31:0] pc, input logic [2:0] cause,
                             input logic [31:0] exp_dpc);
    @(posedge clk_i);
    drive_idle();
    csr_save_cause_i <= 1'b1;
    debug_csr_save_i <= 1'b1;
    csr_save_id_i    <= 1'b1;
    pc_id_i          <= pc;
    pc_if_i          <= ~pc;
    debug_cause_i    <= dbg_cause_e'(cause);
    @(posedge clk_i);
    drive_idle();
    @(negedge clk_i);
    check_cnt += 2;
    if (depc_o !== exp_dpc) report_mismatch("depc_o", exp_dpc, depc_o);
    if (mepc_o !== exp_mepc) report_mismatch("mepc_o", exp_mepc, mepc_o);
  endtask

  // n load pulses, then two quiet cycles so the last one is counted
  task automatic load_burst(input int n);
    repeat (n) begin
      @(posedge clk_i);
      drive_idle();
      mem_load_i <= 1'b1;
    end
    @(posedge clk_i);
    drive_idle();
    repeat (2) @(posedge clk_i);
  endtask

  task automatic close_test(input int id);
    test_cnt++;
    if (test_err_cnt == 0) $display("test %0d passed", id);
    else $display("test %0d failed with %0d errors", id, test_err_cnt);
    test_err_cnt = 0;
  endtask

  ////////////////////
  // command player
  ////////////////////

  initial begin : main
    logic [3:0]  kind;
    logic [31:0] arg_a;
    logic [31:0] arg_b;
    logic [31:0] expv;
    bit          found_end;
    rst_ni             = 1'b0;
    core_id_i          = 4'h3;
    cluster_id_i       = 6'h15;
    boot_addr_i        = 32'h1C00_8000;
    csr_access_i       = 1'b0;
    csr_op_i           = CSR_OP_NONE;
    csr_addr_i         = '0;
    csr_wdata_i        = '0;
    pc_if_i            = '0;
    pc_id_i            = '0;
    csr_save_if_i      = 1'b0;
    csr_save_id_i      = 1'b0;
    csr_save_cause_i   = 1'b0;
    csr_restore_mret_i = 1'b0;
    csr_restore_dret_i = 1'b0;
    csr_cause_i        = EXC_CAUSE_INSN_ADDR_MISA;
    debug_csr_save_i   = 1'b0;
    debug_cause_i      = DBG_CAUSE_NONE;
    if_valid_i         = 1'b0;
    id_valid_i         = 1'b0;
    is_compressed_i    = 1'b0;
    is_decoding_i      = 1'b0;
    imiss_i            = 1'b0;
    pc_set_i           = 1'b0;
    jump_i             = 1'b0;
    branch_i           = 1'b0;
    branch_taken_i     = 1'b0;
    mem_load_i         = 1'b0;
    mem_store_i        = 1'b0;
    exp_mepc     = '0;  // mepc is zero out of reset
    err_cnt      = 0;
    test_err_cnt = 0;
    test_cnt     = 0;
    check_cnt    = 0;

    $readmemh("tests/csr_stimulus.txt", stim_mem);
    n_cmds    = 0;
    found_end = 1'b0;
    for (int i = 0; i < MAX_CMDS && !found_end; i++) begin
      if (stim_mem[4*i] == 32'hF) found_end = 1'b1;
      else n_cmds++;
    end
    cycle_limit = CYC_PER_CMD * (n_cmds + 1) + RESET_CYCLES;

    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;

    if (!found_end) begin
      $display("stimulus file is missing or has no end marker");
      err_cnt++;
    end else begin
      for (int i = 0; i < n_cmds; i++) begin
        kind  = stim_mem[4*i][3:0];
        arg_a = stim_mem[4*i+1];
        arg_b = stim_mem[4*i+2];
        expv  = stim_mem[4*i+3];
        case (kind)
          K_END_TEST: close_test(int'(arg_b));
          K_WRITE:    issue_access(CSR_OP_WRITE, arg_a[11:0], arg_b);
          K_SET:      issue_access(CSR_OP_SET, arg_a[11:0], arg_b);
          K_CLEAR:    issue_access(CSR_OP_CLEAR, arg_a[11:0], arg_b);
          K_READ:     read_expect(arg_a[11:0], expv);
          K_TRAP:     trap_entry(arg_a, arg_b[5:0], expv);
          K_MRET:     mret_exit(expv[0]);
          K_DEBUG:    debug_entry(arg_a, arg_b[2:0], expv);
          K_BURST:    load_burst(int'(arg_b));
          default: begin
            $display("unknown command kind %h on stimulus entry %0d", kind, i);
            err_cnt++;
          end
        endcase
      end
    end

    @(posedge clk_i);
    drive_idle();
    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // run limit from the stimulus length
  initial begin : watchdog
    cycle_cnt = 0;
    @(posedge clk_i);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, the run did not finish", cycle_cnt);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+source
source/csr_addr_pkg.sv
source/csr_state_pkg.sv
source/csr_bus_if.sv
source/csr_machine_bank.sv
source/csr_perf_bank.sv
source/csr_access_ctrl.sv
source/csr_unit.sv
tests/tb_csr_unit.sv

// File: Makefile
# Verilator build, run, lint and clean for the csr unit testbench
TOP := tb_csr_unit

.PHONY: all build run lint clean

all: run

build:
	verilator --binary -Wno-fatal -f flist.f --top-module $(TOP) --Mdir obj_dir -o $(TOP)

# pass only when the testbench prints its pass line
run: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

lint:
	verilator --lint-only -Wall -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: tests/csr_stimulus.txt
// columns: kind addr_or_pc operand expected, all hex
// kinds: 0 end of test, 1 write, 2 set, 3 clear, 4 read, 5 trap, 6 mret, 7 debug, 8 loads, F end
// 1 operations on dscratch0
1 7B2 A5A50F0F 0
4 7B2 0 A5A50F0F
2 7B2 0000F0F0 0
4 7B2 0 A5A5FFFF
3 7B2 A5000000 0
4 7B2 0 00A5FFFF
0 0 1 0
// 2 read-only and fixed fields
4 301 0 40000104
4 F14 0 000002A3
4 305 0 1C008000
1 7B1 00002000 0
1 7B1 00002001 0
4 7B1 0 00002000
1 7B0 FFFFFFFF 0
4 7B0 0 4000B9C7
0 0 2 0
// 3 trap entry and mret
1 300 00000008 0
4 300 0 00001808
5 00000420 2B 00000420
4 341 0 00000420
4 342 0 8000000B
4 300 0 00001880
6 0 0 1
4 300 0 00001888
0 0 3 0
// 4 debug save
7 00000630 3 00000630
4 7B0 0 4000B8C7
4 341 0 00000420
0 0 4 0
// 5 load counting
1 7A0 00000021 0
1 785 0 0
8 0 5 0
1 7A1 0 0
4 785 0 00000005
0 0 5 0
// 6 saturate then wrap
1 7A1 3 0
1 785 FFFFFFFF 0
8 0 3 0
4 785 0 FFFFFFFF
1 7A1 1 0
8 0 1 0
4 785 0 00000000
0 0 6 0
F 0 0 0
